// ==== Makefile ====
VERILATOR ?= verilator
TOP := tb_fei4_rx
FILELIST := sources.f
BUILD_DIR := obj_dir
LINT_FLAGS := --lint-only --timing --assert
SIM_FLAGS := --binary --timing --assert -j 0
PASS_MSG := Done: no errors

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) $(SIM_FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) | tee /dev/stderr | grep -q "$(PASS_MSG)"

clean:
	rm -rf $(BUILD_DIR)

// ==== common/fei4_rx_pkg.sv ====
`default_nettype none

package fei4_rx_pkg;

    // aligned line symbol, first received bit in bit 0
    typedef logic [9:0] symbol_t;
    typedef logic [7:0] byte_t;
    typedef logic [23:0] record_t;

    // decoded K28 control bytes
    localparam byte_t K_COMMA = 8'hBC; // K28.5
    localparam byte_t K_SOF = 8'hFC;   // K28.7
    localparam byte_t K_EOF = 8'h7C;   // K28.3

    // K28.5 as seen on the line, bit a in bit 0
    localparam symbol_t COMMA_NEG = 10'b0101111100; // rd-
    localparam symbol_t COMMA_POS = 10'b1010000011; // rd+

    // commas in a row at one phase before ready
    localparam int SYNC_COMMAS = 4;

    localparam byte_t VERSION = 8'd3;

    typedef enum logic [1:0] {
        IDLE,
        BYTE0,
        BYTE1,
        BYTE2
    } frame_state_t;

endpackage

`default_nettype wire

// ==== logic/fei4_rx_core.sv ====
`timescale 1ns/1ps
`default_nettype none

module fei4_rx_core #(
    parameter int ABUSWIDTH = 16,
    parameter logic [7:0] DATA_IDENTIFIER = 8'h00,
    parameter int FIFO_DEPTH = 16
) (
    input wire BUS_CLK,
    input wire RST,
    input wire [ABUSWIDTH-1:0] BUS_ADD,
    input wire [7:0] BUS_DATA_IN,
    input wire BUS_WR,
    input wire BUS_RD,
    output logic [7:0] BUS_DATA_OUT,
    input wire RX_DATA,
    output logic RX_READY,
    output logic RX_ENABLED,
    output logic RX_8B10B_DECODER_ERR,
    output logic RX_FIFO_OVERFLOW_ERR,
    output logic RX_FIFO_FULL,
    input wire FIFO_READ,
    output logic FIFO_EMPTY,
    output logic [31:0] FIFO_DATA
);

    localparam logic [ABUSWIDTH-1:0] ADDR_SOFT_RST = ABUSWIDTH'(0);
    localparam logic [ABUSWIDTH-1:0] ADDR_RX_RST = ABUSWIDTH'(1);
    localparam logic [ABUSWIDTH-1:0] ADDR_CONF = ABUSWIDTH'(2);
    localparam logic [ABUSWIDTH-1:0] ADDR_SIZE_LO = ABUSWIDTH'(3);
    localparam logic [ABUSWIDTH-1:0] ADDR_SIZE_HI = ABUSWIDTH'(4);
    localparam logic [ABUSWIDTH-1:0] ADDR_DEC_ERR = ABUSWIDTH'(5);
    localparam logic [ABUSWIDTH-1:0] ADDR_LOST = ABUSWIDTH'(6);

    logic soft_rst_ff;
    logic soft_rst_ff2;
    logic rx_rst_ff;
    logic rx_rst_ff2;
    logic soft_rst;   // one-cycle strobe
    logic rx_rst;     // one-cycle strobe
    logic conf_rst;
    logic logic_rst;

    logic [7:1] conf; // bit 0 reads back as ready
    fei4_rx_pkg::byte_t size_hi;
    fei4_rx_pkg::byte_t decoder_err_cnt;
    fei4_rx_pkg::byte_t lost_err_cnt;
    fei4_rx_pkg::record_t fe_data;
    logic [15:0] fifo_size;
    logic ready_rec;

    // register the write strobes, then take the rising edge
    always_ff @(posedge BUS_CLK) begin
        if (RST) begin
            soft_rst_ff <= 1'b0;
            soft_rst_ff2 <= 1'b0;
            rx_rst_ff <= 1'b0;
            rx_rst_ff2 <= 1'b0;
        end else begin
            soft_rst_ff <= BUS_WR && (BUS_ADD == ADDR_SOFT_RST);
            soft_rst_ff2 <= soft_rst_ff;
            rx_rst_ff <= BUS_WR && (BUS_ADD == ADDR_RX_RST);
            rx_rst_ff2 <= rx_rst_ff;
        end
    end

    assign soft_rst = soft_rst_ff & ~soft_rst_ff2;
    assign rx_rst = rx_rst_ff & ~rx_rst_ff2;
    assign conf_rst = RST | soft_rst;
    assign logic_rst = conf_rst | rx_rst; // receiver reset keeps the config

    always_ff @(posedge BUS_CLK) begin
        if (conf_rst)
            conf <= 7'd0; // receiver off
        else if (BUS_WR && BUS_ADD == ADDR_CONF)
            conf <= BUS_DATA_IN[7:1];
    end

    // high byte frozen when the low byte is read
    always_ff @(posedge BUS_CLK) begin
        if (BUS_RD && BUS_ADD == ADDR_SIZE_LO)
            size_hi <= fifo_size[15:8];
    end

    always_ff @(posedge BUS_CLK) begin
        if (BUS_RD) begin
            case (BUS_ADD)
                ADDR_SOFT_RST: BUS_DATA_OUT <= fei4_rx_pkg::VERSION;
                ADDR_CONF: BUS_DATA_OUT <= {conf, RX_READY};
                ADDR_SIZE_LO: BUS_DATA_OUT <= fifo_size[7:0];
                ADDR_SIZE_HI: BUS_DATA_OUT <= size_hi;
                ADDR_DEC_ERR: BUS_DATA_OUT <= decoder_err_cnt;
                ADDR_LOST: BUS_DATA_OUT <= lost_err_cnt;
                default: BUS_DATA_OUT <= 8'd0;
            endcase
        end
    end

    assign RX_ENABLED = conf[2];
    assign RX_READY = ready_rec & conf[2];
    assign RX_8B10B_DECODER_ERR = (decoder_err_cnt != 8'd0);
    assign RX_FIFO_OVERFLOW_ERR = (lost_err_cnt != 8'd0);
    assign FIFO_DATA = {DATA_IDENTIFIER, fe_data};

    receiver_logic #(
        .FIFO_DEPTH(FIFO_DEPTH)
    ) u_receiver_logic (
        .BUS_CLK(BUS_CLK),
        .reset(logic_rst),
        .rx_data(RX_DATA),
        .invert_rx_data(conf[1]),
        .enable_rx(conf[2]),
        .read(FIFO_READ),
        .data(fe_data),
        .empty(FIFO_EMPTY),
        .full(RX_FIFO_FULL),
        .rec_sync_ready(ready_rec),
        .decoder_err_cnt(decoder_err_cnt),
        .lost_err_cnt(lost_err_cnt),
        .fifo_size(fifo_size)
    );

endmodule

`default_nettype wire

// ==== logic/rx_fifo.sv ====
`timescale 1ns/1ps
`default_nettype none

module rx_fifo #(
    parameter int FIFO_DEPTH = 16
) (
    input wire BUS_CLK,
    input wire reset,
    input wire fei4_rx_pkg::record_t wr_data,
    input wire wr,
    input wire rd,
    output fei4_rx_pkg::record_t rd_data,
    output logic empty,
    output logic full,
    output logic [15:0] count,
    output fei4_rx_pkg::byte_t lost_cnt
);

    localparam int AW = $clog2(FIFO_DEPTH);

    fei4_rx_pkg::record_t mem [FIFO_DEPTH];
    logic [AW-1:0] wr_ptr;
    logic [AW-1:0] rd_ptr;
    logic [AW:0] fill;
    logic do_wr;
    logic do_rd;

    assign empty = (fill == '0);
    assign full = (fill == (AW+1)'(FIFO_DEPTH));
    assign do_wr = wr && !full; // full drops the record
    assign do_rd = rd && !empty;

    always_ff @(posedge BUS_CLK) begin
        if (do_wr)
            mem[wr_ptr] <= wr_data;
    end

    always_ff @(posedge BUS_CLK) begin
        if (reset) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            fill <= '0;
            lost_cnt <= 8'd0;
        end else begin
            if (do_wr)
                wr_ptr <= wr_ptr + 1'b1;
            if (do_rd)
                rd_ptr <= rd_ptr + 1'b1;
            if (do_wr && !do_rd)
                fill <= fill + 1'b1;
            else if (do_rd && !do_wr)
                fill <= fill - 1'b1;
            if (wr && full && lost_cnt != 8'hFF)
                lost_cnt <= lost_cnt + 8'd1; // saturates
        end
    end

    // head word is visible without a read
    assign rd_data = mem[rd_ptr];
    assign count = 16'(fill);

endmodule

`default_nettype wire

// ==== receiver/dec_8b10b.sv ====
`timescale 1ns/1ps
`default_nettype none

module dec_8b10b (
    input wire BUS_CLK,
    input wire reset,
    input wire fei4_rx_pkg::symbol_t sym,
    input wire sym_valid,
    output fei4_rx_pkg::byte_t dec_byte,
    output logic dec_k,
    output logic dec_err,
    output logic dec_valid
);

    logic [5:0] abcdei;
    logic [3:0] fghj;
    logic [3:0] fghj_k; // K28 tail folded onto its rd- form
    logic [4:0] edcba;
    logic [2:0] hgf;
    logic k28;
    logic err6;
    logic err4;

    always_comb begin
        abcdei = {sym[0], sym[1], sym[2], sym[3], sym[4], sym[5]};
        fghj = {sym[6], sym[7], sym[8], sym[9]};
        k28 = (abcdei == 6'b001111) || (abcdei == 6'b110000);
        fghj_k = (abcdei == 6'b110000) ? ~fghj : fghj;
        err6 = 1'b0;
        err4 = 1'b0;

        // 6b to 5b, both disparities
        case (abcdei)
            6'b100111, 6'b011000: edcba = 5'd0;
            6'b011101, 6'b100010: edcba = 5'd1;
            6'b101101, 6'b010010: edcba = 5'd2;
            6'b110001: edcba = 5'd3;
            6'b110101, 6'b001010: edcba = 5'd4;
            6'b101001: edcba = 5'd5;
            6'b011001: edcba = 5'd6;
            6'b111000, 6'b000111: edcba = 5'd7;
            6'b111001, 6'b000110: edcba = 5'd8;
            6'b100101: edcba = 5'd9;
            6'b010101: edcba = 5'd10;
            6'b110100: edcba = 5'd11;
            6'b001101: edcba = 5'd12;
            6'b101100: edcba = 5'd13;
            6'b011100: edcba = 5'd14;
            6'b010111, 6'b101000: edcba = 5'd15;
            6'b011011, 6'b100100: edcba = 5'd16;
            6'b100011: edcba = 5'd17;
            6'b010011: edcba = 5'd18;
            6'b110010: edcba = 5'd19;
            6'b001011: edcba = 5'd20;
            6'b101010: edcba = 5'd21;
            6'b011010: edcba = 5'd22;
            6'b111010, 6'b000101: edcba = 5'd23;
            6'b110011, 6'b001100: edcba = 5'd24;
            6'b100110: edcba = 5'd25;
            6'b010110: edcba = 5'd26;
            6'b110110, 6'b001001: edcba = 5'd27;
            6'b001110, 6'b001111, 6'b110000: edcba = 5'd28; // D28 and K28
            6'b101110, 6'b010001: edcba = 5'd29;
            6'b011110, 6'b100001: edcba = 5'd30;
            6'b101011, 6'b010100: edcba = 5'd31;
            default: begin
                edcba = 5'd0;
                err6 = 1'b1;
            end
        endcase

        // 4b to 3b
        if (k28) begin
            case (fghj_k)
                4'b0100: hgf = 3'd0;
                4'b1001: hgf = 3'd1;
                4'b0101: hgf = 3'd2;
                4'b0011: hgf = 3'd3;
                4'b0010: hgf = 3'd4;
                4'b1010: hgf = 3'd5;
                4'b0110: hgf = 3'd6;
                4'b1000: hgf = 3'd7;
                default: begin
                    hgf = 3'd0;
                    err4 = 1'b1;
                end
            endcase
        end else begin
            case (fghj)
                4'b1011, 4'b0100: hgf = 3'd0;
                4'b1001: hgf = 3'd1;
                4'b0101: hgf = 3'd2;
                4'b1100, 4'b0011: hgf = 3'd3;
                4'b1101, 4'b0010: hgf = 3'd4;
                4'b1010: hgf = 3'd5;
                4'b0110: hgf = 3'd6;
                4'b1110, 4'b0001, 4'b0111, 4'b1000: hgf = 3'd7; // primary and alternate
                default: begin
                    hgf = 3'd0;
                    err4 = 1'b1;
                end
            endcase
        end
    end

    always_ff @(posedge BUS_CLK) begin
        if (reset)
            dec_valid <= 1'b0;
        else
            dec_valid <= sym_valid;
    end

    always_ff @(posedge BUS_CLK) begin
        if (sym_valid) begin
            dec_byte <= {hgf, edcba};
            dec_k <= k28;
            dec_err <= err6 | err4;
        end
    end

endmodule

`default_nettype wire

// ==== receiver/frame_builder.sv ====
`timescale 1ns/1ps
`default_nettype none

module frame_builder (
    input wire BUS_CLK,
    input wire reset,
    input wire fei4_rx_pkg::byte_t dec_byte,
    input wire dec_k,
    input wire dec_valid,
    output fei4_rx_pkg::record_t rec,
    output logic rec_valid
);

    fei4_rx_pkg::frame_state_t state;
    fei4_rx_pkg::byte_t byte0;
    fei4_rx_pkg::byte_t byte1;

    always_ff @(posedge BUS_CLK) begin
        if (reset) begin
            state <= fei4_rx_pkg::IDLE;
        end else if (dec_valid) begin
            if (dec_k) begin
                if (dec_byte == fei4_rx_pkg::K_SOF)
                    state <= fei4_rx_pkg::BYTE0;
                else if (dec_byte == fei4_rx_pkg::K_EOF)
                    state <= fei4_rx_pkg::IDLE; // partial record is dropped
            end else begin
                case (state)
                    fei4_rx_pkg::BYTE0: state <= fei4_rx_pkg::BYTE1;
                    fei4_rx_pkg::BYTE1: state <= fei4_rx_pkg::BYTE2;
                    fei4_rx_pkg::BYTE2: state <= fei4_rx_pkg::BYTE0;
                    default: state <= fei4_rx_pkg::IDLE; // data outside a frame
                endcase
            end
        end
    end

    always_ff @(posedge BUS_CLK) begin
        if (dec_valid && !dec_k) begin
            if (state == fei4_rx_pkg::BYTE0)
                byte0 <= dec_byte;
            if (state == fei4_rx_pkg::BYTE1)
                byte1 <= dec_byte;
        end
    end

    // third byte goes straight out with the two held ones
    assign rec = {byte0, byte1, dec_byte};
    assign rec_valid = dec_valid && !dec_k && (state == fei4_rx_pkg::BYTE2);

endmodule

`default_nettype wire

// ==== receiver/receiver_logic.sv ====
`timescale 1ns/1ps
`default_nettype none

module receiver_logic #(
    parameter int FIFO_DEPTH = 16
) (
    input wire BUS_CLK,
    input wire reset,
    input wire rx_data,
    input wire invert_rx_data,
    input wire enable_rx,
    input wire read,
    output fei4_rx_pkg::record_t data,
    output logic empty,
    output logic full,
    output logic rec_sync_ready,
    output fei4_rx_pkg::byte_t decoder_err_cnt,
    output fei4_rx_pkg::byte_t lost_err_cnt,
    output logic [15:0] fifo_size
);

    fei4_rx_pkg::symbol_t sym;
    logic sym_valid;
    fei4_rx_pkg::byte_t dec_byte;
    logic dec_k;
    logic dec_err;
    logic dec_valid;
    fei4_rx_pkg::record_t rec;
    logic rec_valid;

    rx_sync u_rx_sync (
        .BUS_CLK(BUS_CLK),
        .reset(reset),
        .rx_bit(rx_data ^ invert_rx_data),
        .enable(enable_rx),
        .sym(sym),
        .sym_valid(sym_valid),
        .ready(rec_sync_ready)
    );

    dec_8b10b u_dec_8b10b (
        .BUS_CLK(BUS_CLK),
        .reset(reset),
        .sym(sym),
        .sym_valid(sym_valid),
        .dec_byte(dec_byte),
        .dec_k(dec_k),
        .dec_err(dec_err),
        .dec_valid(dec_valid)
    );

    frame_builder u_frame_builder (
        .BUS_CLK(BUS_CLK),
        .reset(reset),
        .dec_byte(dec_byte),
        .dec_k(dec_k),
        .dec_valid(dec_valid),
        .rec(rec),
        .rec_valid(rec_valid)
    );

    rx_fifo #(
        .FIFO_DEPTH(FIFO_DEPTH)
    ) u_rx_fifo (
        .BUS_CLK(BUS_CLK),
        .reset(reset),
        .wr_data(rec),
        .wr(rec_valid),
        .rd(read),
        .rd_data(data),
        .empty(empty),
        .full(full),
        .count(fifo_size),
        .lost_cnt(lost_err_cnt)
    );

    // invalid codes only, stops at 255
    always_ff @(posedge BUS_CLK) begin
        if (reset)
            decoder_err_cnt <= 8'd0;
        else if (dec_valid && dec_err && decoder_err_cnt != 8'hFF)
            decoder_err_cnt <= decoder_err_cnt + 8'd1;
    end

endmodule

`default_nettype wire

// ==== receiver/rx_sync.sv ====
`timescale 1ns/1ps
`default_nettype none

module rx_sync (
    input wire BUS_CLK,
    input wire reset,
    input wire rx_bit,
    input wire enable,
    output fei4_rx_pkg::symbol_t sym,
    output logic sym_valid,
    output logic ready
);

    fei4_rx_pkg::symbol_t win;
    logic [3:0] bit_cnt;   // bits since the last symbol boundary
    logic [2:0] comma_cnt;
    logic comma_hit;

    // newest bit enters at the top, oldest ends up in bit 0
    always_ff @(posedge BUS_CLK) begin
        if (enable)
            win <= {rx_bit, win[9:1]};
    end

    assign comma_hit = (win == fei4_rx_pkg::COMMA_NEG) || (win == fei4_rx_pkg::COMMA_POS);

    always_ff @(posedge BUS_CLK) begin
        if (reset || !enable) begin
            bit_cnt <= 4'd0;
            comma_cnt <= 3'd0;
            ready <= 1'b0;
        end else begin
            bit_cnt <= (bit_cnt == 4'd9) ? 4'd0 : bit_cnt + 4'd1;
            if (!ready) begin
                if (comma_hit) begin
                    bit_cnt <= 4'd0; // window now sits on a boundary
                    if (comma_cnt != 3'd0 && bit_cnt == 4'd9) begin
                        comma_cnt <= comma_cnt + 3'd1;
                        if (comma_cnt == 3'(fei4_rx_pkg::SYNC_COMMAS - 1))
                            ready <= 1'b1;
                    end else begin
                        comma_cnt <= 3'd1; // first comma or a new phase
                    end
                end else if (bit_cnt == 4'd9) begin
                    comma_cnt <= 3'd0; // expected comma missing
                end
            end
        end
    end

    // once aligned, every tenth window is a full symbol
    assign sym = win;
    assign sym_valid = enable && ready && (bit_cnt == 4'd9);

endmodule

`default_nettype wire

// ==== sources.f ====
common/fei4_rx_pkg.sv
receiver/rx_sync.sv
receiver/dec_8b10b.sv
receiver/frame_builder.sv
logic/rx_fifo.sv
receiver/receiver_logic.sv
logic/fei4_rx_core.sv
verif/fei4_rx_checker.sv
verif/tb_fei4_rx.sv

// ==== verif/fei4_rx_checker.sv ====
`timescale 1ns/1ps
`default_nettype none

module fei4_rx_checker (
    input wire BUS_CLK,
    input wire RST,
    input wire RX_READY,
    input wire RX_ENABLED,
    input wire FIFO_EMPTY,
    input wire FIFO_READ,
    input wire sync_ready,
    input wire soft_rst,
    input wire rx_rst
);

    int fail_count = 0;

    // receiver sync drops one cycle after the enable bit clears
    sync_needs_enable: assert property (@(posedge BUS_CLK) disable iff (RST)
        !RX_ENABLED |=> !sync_ready)
        else begin
            $error("receiver sync still high a cycle after RX_ENABLED went low");
            fail_count++;
        end

    // a stored record stays until popped or reset
    record_held_until_read: assert property (@(posedge BUS_CLK) disable iff (RST)
        (!FIFO_EMPTY && !FIFO_READ && !soft_rst && !rx_rst) |=> !FIFO_EMPTY)
        else begin
            $error("FIFO_EMPTY went high without a read or reset");
            fail_count++;
        end

    // a reset strobe always leaves the receiver unsynced
    strobe_clears_ready: assert property (@(posedge BUS_CLK) disable iff (RST)
        (soft_rst || rx_rst) |=> !RX_READY)
        else begin
            $error("RX_READY high right after a reset strobe");
            fail_count++;
        end

endmodule

bind fei4_rx_core fei4_rx_checker u_checker (
    .BUS_CLK(BUS_CLK),
    .RST(RST),
    .RX_READY(RX_READY),
    .RX_ENABLED(RX_ENABLED),
    .FIFO_EMPTY(FIFO_EMPTY),
    .FIFO_READ(FIFO_READ),
    .sync_ready(ready_rec),
    .soft_rst(soft_rst),
    .rx_rst(rx_rst)
);

`default_nettype wire

// ==== verif/tb_fei4_rx.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_fei4_rx;

    localparam logic [7:0] ID = 8'hD4;
    localparam int DEPTH = 4;
    localparam logic [1:0] KIND_DATA = 2'd0;
    localparam logic [1:0] KIND_K = 2'd1;
    localparam logic [1:0] KIND_RAW = 2'd2;
    // about 90 symbols of traffic plus bus cycles, doubled for margin
    localparam int RUN_SYMBOLS = 90;
    localparam int WATCHDOG_CYCLES = 2 * (RUN_SYMBOLS * 10 + 400);

    logic BUS_CLK;
    logic RST;
    logic [15:0] BUS_ADD;
    logic [7:0] BUS_DATA_IN;
    logic BUS_WR;
    logic BUS_RD;
    logic [7:0] BUS_DATA_OUT;
    logic RX_DATA;
    logic RX_READY;
    logic RX_ENABLED;
    logic RX_8B10B_DECODER_ERR;
    logic RX_FIFO_OVERFLOW_ERR;
    logic RX_FIFO_FULL;
    logic FIFO_READ;
    logic FIFO_EMPTY;
    logic [31:0] FIFO_DATA;

    logic [11:0] line_q[$]; // {kind, payload} waiting for the serializer
    logic [7:0] exp_bytes[$];
    logic line_inv;
    int sym_sent;
    int errors;
    int failed_tests;
    int seed;

    fei4_rx_core #(
        .ABUSWIDTH(16),
        .DATA_IDENTIFIER(ID),
        .FIFO_DEPTH(DEPTH)
    ) u_dut (
        .BUS_CLK(BUS_CLK),
        .RST(RST),
        .BUS_ADD(BUS_ADD),
        .BUS_DATA_IN(BUS_DATA_IN),
        .BUS_WR(BUS_WR),
        .BUS_RD(BUS_RD),
        .BUS_DATA_OUT(BUS_DATA_OUT),
        .RX_DATA(RX_DATA),
        .RX_READY(RX_READY),
        .RX_ENABLED(RX_ENABLED),
        .RX_8B10B_DECODER_ERR(RX_8B10B_DECODER_ERR),
        .RX_FIFO_OVERFLOW_ERR(RX_FIFO_OVERFLOW_ERR),
        .RX_FIFO_FULL(RX_FIFO_FULL),
        .FIFO_READ(FIFO_READ),
        .FIFO_EMPTY(FIFO_EMPTY),
        .FIFO_DATA(FIFO_DATA)
    );

    initial begin
        BUS_CLK = 1'b0;
        forever #5 BUS_CLK = ~BUS_CLK;
    end

    // standard 5b/6b codes for rd-, abcdei with a as MSB
    function automatic logic [5:0] six_bit_code(input logic [4:0] x);
        logic [5:0] c;
        case (x)
            5'd0: c = 6'b100111;
            5'd1: c = 6'b011101;
            5'd2: c = 6'b101101;
            5'd3: c = 6'b110001;
            5'd4: c = 6'b110101;
            5'd5: c = 6'b101001;
            5'd6: c = 6'b011001;
            5'd7: c = 6'b111000;
            5'd8: c = 6'b111001;
            5'd9: c = 6'b100101;
            5'd10: c = 6'b010101;
            5'd11: c = 6'b110100;
            5'd12: c = 6'b001101;
            5'd13: c = 6'b101100;
            5'd14: c = 6'b011100;
            5'd15: c = 6'b010111;
            5'd16: c = 6'b011011;
            5'd17: c = 6'b100011;
            5'd18: c = 6'b010011;
            5'd19: c = 6'b110010;
            5'd20: c = 6'b001011;
            5'd21: c = 6'b101010;
            5'd22: c = 6'b011010;
            5'd23: c = 6'b111010;
            5'd24: c = 6'b110011;
            5'd25: c = 6'b100110;
            5'd26: c = 6'b010110;
            5'd27: c = 6'b110110;
            5'd28: c = 6'b001110;
            5'd29: c = 6'b101110;
            5'd30: c = 6'b011110;
            default: c = 6'b101011;
        endcase
        return c;
    endfunction

    // returns {new rd, abcdeifghj}, rd 1 means positive
    function automatic logic [10:0] encode_symbol(input logic k, input logic [7:0] b,
                                                  input logic rd);
        logic [5:0] c6;
        logic [3:0] c4;
        logic [9:0] full;
        logic rd_mid;
        logic alt;
        if (k) begin
            case (b[7:5]) // K28.3, K28.5, K28.7 tails
                3'd5: c4 = 4'b1010;
                3'd7: c4 = 4'b1000;
                default: c4 = 4'b0011;
            endcase
            full = {6'b001111, c4};
            if (rd)
                full = ~full;
            return {rd ^ ($countones(full) != 5), full};
        end
        c6 = six_bit_code(b[4:0]);
        rd_mid = rd ^ ($countones(c6) != 3);
        if (rd && ($countones(c6) != 3 || b[4:0] == 5'd7))
            c6 = ~c6;
        case (b[7:5])
            3'd0: c4 = 4'b1011;
            3'd1: c4 = 4'b1001;
            3'd2: c4 = 4'b0101;
            3'd3: c4 = 4'b1100;
            3'd4: c4 = 4'b1101;
            3'd5: c4 = 4'b1010;
            3'd6: c4 = 4'b0110;
            default: begin
                alt = rd_mid ? (b[4:0] == 5'd11 || b[4:0] == 5'd13 || b[4:0] == 5'd14)
                             : (b[4:0] == 5'd17 || b[4:0] == 5'd18 || b[4:0] == 5'd20);
                c4 = alt ? 4'b0111 : 4'b1110;
            end
        endcase
        if (rd_mid && ($countones(c4) != 2 || b[7:5] == 3'd3))
            c4 = ~c4;
        return {rd_mid ^ ($countones(c4) != 2), c6, c4};
    endfunction

    // serializer, idle line carries commas
    initial begin : serializer
        logic [11:0] item;
        logic [10:0] enc;
        logic rd;
        rd = 1'b0;
        repeat (4) @(posedge BUS_CLK);
        forever begin
            if (line_q.size() > 0)
                item = line_q.pop_front();
            else
                item = {KIND_K, 2'b00, 8'hBC};
            if (item[11:10] == KIND_RAW) begin
                enc = {rd, item[9:0]};
            end else begin
                enc = encode_symbol(item[11:10] == KIND_K, item[7:0], rd);
                rd = enc[10];
            end
            for (int i = 9; i >= 0; i--) begin
                @(posedge BUS_CLK);
                RX_DATA <= enc[i] ^ line_inv; // a goes out first
            end
            sym_sent++;
        end
    end

    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge BUS_CLK);
        $display("watchdog expired before the tests finished");
        $display("Done: errors found");
        $finish;
    end

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        if (got !== exp) begin
            $display("ERR %s: got 0x%0h expected 0x%0h", name, got, exp);
            errors++;
        end
    endtask

    task automatic bus_write(input logic [15:0] addr, input logic [7:0] data);
        @(posedge BUS_CLK);
        BUS_ADD <= addr;
        BUS_DATA_IN <= data;
        BUS_WR <= 1'b1;
        @(posedge BUS_CLK);
        BUS_WR <= 1'b0;
    endtask

    task automatic bus_read(input logic [15:0] addr, output logic [7:0] data,
                            output logic rdy);
        @(posedge BUS_CLK);
        BUS_ADD <= addr;
        BUS_RD <= 1'b1;
        @(posedge BUS_CLK);
        BUS_RD <= 1'b0;
        rdy = RX_READY; // value the DUT sampled with the read
        @(posedge BUS_CLK);
        data = BUS_DATA_OUT;
    endtask

    task automatic wait_symbols(input int n);
        int start;
        start = sym_sent;
        while (sym_sent < start + n)
            @(posedge BUS_CLK);
    endtask

    // line empty, then one more symbol covers the decode latency
    task automatic wait_drained();
        while (line_q.size() > 0)
            @(posedge BUS_CLK);
        wait_symbols(2);
    endtask

    task automatic wait_ready(output logic ok);
        int cycles;
        cycles = 0;
        while (!RX_READY && cycles < (fei4_rx_pkg::SYNC_COMMAS + 2) * 10) begin
            @(posedge BUS_CLK);
            cycles++;
        end
        ok = RX_READY;
    endtask

    task automatic send_frame(input int nbytes);
        logic [7:0] b;
        line_q.push_back({KIND_K, 2'b00, 8'hFC});
        for (int i = 0; i < nbytes; i++) begin
            b = 8'($random(seed));
            exp_bytes.push_back(b);
            line_q.push_back({KIND_DATA, 2'b00, b});
        end
        line_q.push_back({KIND_K, 2'b00, 8'h7C});
    endtask

    task automatic pop_record(input logic do_pop);
        logic [31:0] exp;
        @(posedge BUS_CLK);
        if (FIFO_EMPTY) begin
            $display("FIFO empty where a record was expected");
            errors++;
        end
        exp = {ID, exp_bytes[0], exp_bytes[1], exp_bytes[2]};
        check_value("FIFO_DATA", FIFO_DATA, exp);
        if (do_pop) begin
            repeat (3) void'(exp_bytes.pop_front());
            FIFO_READ <= 1'b1;
            @(posedge BUS_CLK);
            FIFO_READ <= 1'b0;
        end
    endtask

    task automatic finish_test(input string name, input int errs_before);
        if (errors == errs_before) begin
            $display("%s: ok", name);
        end else begin
            $display("%s: FAILED", name);
            failed_tests++;
        end
    endtask

    task automatic test_registers();
        int e0;
        logic [7:0] d;
        logic r;
        e0 = errors;
        bus_read(16'd0, d, r);
        check_value("version", d, 8'd3);
        bus_write(16'd2, 8'h06);
        bus_read(16'd2, d, r);
        check_value("conf", d, {7'b0000011, r});
        check_value("RX_ENABLED", RX_ENABLED, 1'b1);
        bus_write(16'd2, 8'h00);
        @(posedge BUS_CLK);
        check_value("RX_ENABLED", RX_ENABLED, 1'b0);
        finish_test("registers", e0);
    endtask

    task automatic test_sync();
        int e0;
        logic ok;
        e0 = errors;
        wait_symbols(5);
        check_value("RX_READY", RX_READY, 1'b0); // still disabled
        bus_write(16'd2, 8'h04);
        wait_ready(ok);
        if (!ok) begin
            $display("receiver did not reach ready on a comma stream");
            errors++;
        end
        finish_test("sync", e0);
    endtask

    task automatic test_records(input string name);
        int e0;
        logic [7:0] d;
        logic r;
        e0 = errors;
        send_frame(6);
        wait_drained();
        bus_read(16'd3, d, r);
        check_value("fifo size lo", d, 8'd2);
        bus_read(16'd4, d, r);
        check_value("fifo size hi", d, 8'd0);
        pop_record(1'b1);
        pop_record(1'b1);
        @(posedge BUS_CLK);
        check_value("FIFO_EMPTY", FIFO_EMPTY, 1'b1);
        finish_test(name, e0);
    endtask

    task automatic test_inversion();
        logic ok;
        bus_write(16'd2, 8'h00);
        line_inv <= 1'b1;
        bus_write(16'd2, 8'h06);
        wait_ready(ok);
        if (!ok) begin
            $display("receiver did not resync on the inverted line");
            errors++;
        end
        test_records("inversion");
    endtask

    task automatic test_decoder_errors();
        int e0;
        logic [7:0] d;
        logic r;
        e0 = errors;
        repeat (3) line_q.push_back({KIND_RAW, 10'h3FF}); // 111111 is no valid code
        wait_drained();
        bus_read(16'd5, d, r);
        check_value("decoder errors", d, 8'd3);
        check_value("RX_8B10B_DECODER_ERR", RX_8B10B_DECODER_ERR, 1'b1);
        finish_test("decoder errors", e0);
    endtask

    task automatic test_overflow();
        int e0;
        logic [7:0] d;
        logic r;
        e0 = errors;
        send_frame(18); // six records into a four deep FIFO
        wait_drained();
        check_value("RX_FIFO_FULL", RX_FIFO_FULL, 1'b1);
        check_value("RX_FIFO_OVERFLOW_ERR", RX_FIFO_OVERFLOW_ERR, 1'b1);
        bus_read(16'd6, d, r);
        check_value("lost records", d, 8'd2);
        repeat (3) pop_record(1'b1);
        pop_record(1'b0);
        bus_write(16'd0, 8'h00);
        bus_read(16'd5, d, r);
        check_value("decoder errors", d, 8'd0);
        bus_read(16'd6, d, r);
        check_value("lost records", d, 8'd0);
        bus_read(16'd2, d, r);
        check_value("conf", d, 8'd0);
        check_value("FIFO_EMPTY", FIFO_EMPTY, 1'b1);
        check_value("RX_ENABLED", RX_ENABLED, 1'b0);
        finish_test("overflow and soft reset", e0);
    endtask

    initial begin
        RST = 1'b1;
        BUS_ADD = 16'd0;
        BUS_DATA_IN = 8'd0;
        BUS_WR = 1'b0;
        BUS_RD = 1'b0;
        RX_DATA = 1'b0;
        FIFO_READ = 1'b0;
        line_inv = 1'b0;
        sym_sent = 0;
        errors = 0;
        failed_tests = 0;
        seed = 32'ha5961393;
        repeat (3) @(posedge BUS_CLK);
        RST <= 1'b0;
        test_registers();
        test_sync();
        test_records("records");
        test_inversion();
        test_decoder_errors();
        test_overflow();
        errors += u_dut.u_checker.fail_count;
        $display("tests failed: %0d of 6, check errors: %0d", failed_tests, errors);
        if (errors == 0)
            $display("Done: no errors");
        else
            $display("Done: errors found");
        $finish;
    end

endmodule

`default_nettype wire
